// ==== logic/mem_cfg_pkg.sv ====
package mem_cfg_pkg;

  // Width of one memory word in bits.
  parameter int unsigned MEM_DATA_W = 32;

  // Address width and the default word count.
  parameter int unsigned MEM_ADDR_W    = 6;
  parameter int unsigned MEM_DEPTH_DEF = 48;  // Not a power of two on purpose.

  // One memory word.
  typedef logic [MEM_DATA_W-1:0] data_t;

  // Write mask where a set bit selects that bit for writing.
  typedef logic [MEM_DATA_W-1:0] mask_t;

  // Word address into the array.
  typedef logic [MEM_ADDR_W-1:0] addr_t;

endpackage

// ==== logic/mem_cmd_pkg.sv ====
package mem_cmd_pkg;

  // Encoding width of the front-end state register.
  parameter int unsigned FRONT_STATE_W = 2;

  typedef logic [FRONT_STATE_W-1:0] state_bits_t;

  // Front-end handshake states.
  typedef enum state_bits_t {
    IDLE   = 2'd0,  // Waiting for req.
    ACCESS = 2'd1,  // Memory valid pulse.
    RESP   = 2'd2,  // Ack high until req drops.
    DONE   = 2'd3   // Ack dropped, one cycle back to idle.
  } front_state_e;

endpackage

// ==== logic/mem_clock_gate.sv ====
`timescale 1ns/1ps

module mem_clock_gate (
  input  logic clk_lo,
  input  logic en_i,
  input  logic bypass_i,
  output logic gated_clk_o
);

  logic en_lat;

  // Enable is captured only while the clock is low.
  // It is stable over the whole high phase, so the AND cannot glitch.
  always_latch
  begin
    if (!clk_lo)
    begin
      en_lat <= en_i;
    end
  end

  // Bypass forces the clock through.
  assign gated_clk_o = clk_lo & (en_lat | bypass_i);

endmodule

// ==== logic/mem_1rw_mask_bit.sv ====
`timescale 1ns/1ps

module mem_1rw_mask_bit #(
  parameter int unsigned DEPTH        = mem_cfg_pkg::MEM_DEPTH_DEF,
  parameter bit          CLOCK_GATING = 1'b1
) (
  input  logic                clk_lo,
  input  logic                v_i,
  input  logic                w_i,
  input  mem_cfg_pkg::addr_t  addr_i,
  input  mem_cfg_pkg::data_t  data_i,
  input  mem_cfg_pkg::mask_t  w_mask_i,
  output mem_cfg_pkg::data_t  data_o
);

  import mem_cfg_pkg::*;

  logic  gated_clk;         // Array clock that toggles only on access when gating.
  data_t mem_q [DEPTH];     // Word storage without reset.
  data_t data_q;            // Registered read port.

  mem_clock_gate i_mem_clock_gate (
    .clk_lo      (clk_lo),
    .en_i        (v_i),
    .bypass_i    (~CLOCK_GATING),
    .gated_clk_o (gated_clk)
  );

  // Bit-masked write.
  // Masked bits take the new data, all others keep the stored value.
  always_ff @(posedge gated_clk)
  begin
    if (v_i && w_i)
    begin
      mem_q[addr_i] <= (mem_q[addr_i] & ~w_mask_i) | (data_i & w_mask_i);
    end
  end

  // Read data appears one edge after the access and then holds.
  always_ff @(posedge gated_clk)
  begin
    if (v_i && !w_i)
    begin
      data_q <= mem_q[addr_i];
    end
  end

  assign data_o = data_q;

endmodule

// ==== logic/mem_cmd_front.sv ====
`timescale 1ns/1ps

module mem_cmd_front #(
  parameter int unsigned DEPTH = mem_cfg_pkg::MEM_DEPTH_DEF
) (
  input  logic                clk_lo,
  input  logic                arst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  mem_cfg_pkg::addr_t  addr_i,
  input  mem_cfg_pkg::data_t  wdata_i,
  input  mem_cfg_pkg::mask_t  wmask_i,
  output logic                ack_o,
  output logic                err_o,
  output mem_cfg_pkg::data_t  rdata_o,
  output logic                mem_v_o,
  output logic                mem_w_o,
  output mem_cfg_pkg::addr_t  mem_addr_o,
  output mem_cfg_pkg::data_t  mem_wdata_o,
  output mem_cfg_pkg::mask_t  mem_wmask_o,
  input  mem_cfg_pkg::data_t  mem_rdata_i
);

  import mem_cfg_pkg::*;
  import mem_cmd_pkg::*;

  front_state_e state_q;
  front_state_e state_d;
  logic         addr_in_range;
  logic         cmd_start;       // Request seen in idle.
  logic         resp_release;    // Requester dropped req during the response.
  logic         rd_pend_q;       // Read word is still sitting on mem_rdata_i.
  logic         err_q;
  data_t        rdata_q;         // Last read word.
  logic         mem_w_q;
  addr_t        mem_addr_q;
  data_t        mem_wdata_q;
  mask_t        mem_wmask_q;

  // The only range check in the design.
  assign addr_in_range = (32'(addr_i) < DEPTH);
  assign cmd_start     = (state_q == IDLE) && req_i;
  assign resp_release  = (state_q == RESP) && !req_i;

  always_comb
  begin
    state_d = state_q;
    case (state_q)
      IDLE:
      begin
        if (req_i)
        begin
          state_d = addr_in_range ? ACCESS : RESP;  // Bad address skips the array.
        end
      end
      ACCESS: state_d = RESP;
      RESP:
      begin
        if (!req_i)
        begin
          state_d = DONE;
        end
      end
      default: state_d = IDLE;  // DONE returns to idle.
    endcase
  end

  always_ff @(posedge clk_lo or negedge arst_n_i)
  begin
    if (!arst_n_i)
    begin
      state_q   <= IDLE;
      err_q     <= 1'b0;
      rd_pend_q <= 1'b0;
      rdata_q   <= '0;
    end
    else
    begin
      state_q <= state_d;
      if (cmd_start)
      begin
        err_q <= !addr_in_range;
      end
      if (state_q == ACCESS)
      begin
        rd_pend_q <= !mem_w_q;
      end
      else if (resp_release)
      begin
        rd_pend_q <= 1'b0;
      end
      if (rd_pend_q)
      begin
        rdata_q <= mem_rdata_i;  // Memory holds the word through the response.
      end
    end
  end

  // Command payload for the access cycle.
  always_ff @(posedge clk_lo)
  begin
    if (cmd_start && addr_in_range)
    begin
      mem_w_q     <= we_i;
      mem_addr_q  <= addr_i;
      mem_wdata_q <= wdata_i;
      mem_wmask_q <= wmask_i;
    end
  end

  assign mem_v_o     = (state_q == ACCESS);
  assign mem_w_o     = mem_w_q;
  assign mem_addr_o  = mem_addr_q;
  assign mem_wdata_o = mem_wdata_q;
  assign mem_wmask_o = mem_wmask_q;

  assign ack_o   = (state_q == RESP);
  assign err_o   = err_q;
  assign rdata_o = rd_pend_q ? mem_rdata_i : rdata_q;  // Fresh word on the ack cycle.

endmodule

// ==== logic/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top #(
  parameter int unsigned DEPTH        = mem_cfg_pkg::MEM_DEPTH_DEF,
  parameter bit          CLOCK_GATING = 1'b1
) (
  input  logic                clk_lo,
  input  logic                arst_n_i,
  input  logic                req_i,
  input  logic                we_i,
  input  mem_cfg_pkg::addr_t  addr_i,
  input  mem_cfg_pkg::data_t  wdata_i,
  input  mem_cfg_pkg::mask_t  wmask_i,
  output logic                ack_o,
  output logic                err_o,
  output mem_cfg_pkg::data_t  rdata_o
);

  import mem_cfg_pkg::*;

  // Single-cycle access bus between front end and array.
  logic  mem_v;
  logic  mem_w;
  addr_t mem_addr;
  data_t mem_wdata;
  mask_t mem_wmask;
  data_t mem_rdata;

  mem_cmd_front #(
    .DEPTH (DEPTH)
  ) i_mem_cmd_front (
    .clk_lo      (clk_lo),
    .arst_n_i    (arst_n_i),
    .req_i       (req_i),
    .we_i        (we_i),
    .addr_i      (addr_i),
    .wdata_i     (wdata_i),
    .wmask_i     (wmask_i),
    .ack_o       (ack_o),
    .err_o       (err_o),
    .rdata_o     (rdata_o),
    .mem_v_o     (mem_v),
    .mem_w_o     (mem_w),
    .mem_addr_o  (mem_addr),
    .mem_wdata_o (mem_wdata),
    .mem_wmask_o (mem_wmask),
    .mem_rdata_i (mem_rdata)
  );

  mem_1rw_mask_bit #(
    .DEPTH        (DEPTH),
    .CLOCK_GATING (CLOCK_GATING)
  ) i_mem_1rw_mask_bit (
    .clk_lo   (clk_lo),
    .v_i      (mem_v),
    .w_i      (mem_w),
    .addr_i   (mem_addr),
    .data_i   (mem_wdata),
    .w_mask_i (mem_wmask),
    .data_o   (mem_rdata)
  );

endmodule

// ==== tests/mem_subsys_chk.sv ====
`timescale 1ns/1ps

module mem_subsys_chk #(
  parameter int unsigned DEPTH = mem_cfg_pkg::MEM_DEPTH_DEF
) (
  input logic               clk_lo,
  input logic               arst_n_i,
  input logic               req_i,
  input logic               ack_i,
  input logic               mem_v_i,
  input mem_cfg_pkg::addr_t mem_addr_i
);

  int fail_cnt = 0;  // Number of failed assertions.

  // Ack may only rise while the request is present.
  ack_rise_with_req: assert property (@(posedge clk_lo) disable iff (!arst_n_i)
    $rose(ack_i) |-> req_i)
    else
    begin
      $error("ack rose while req was low");
      fail_cnt++;
    end

  // Ack drops only after req was seen low.
  ack_fall_after_req: assert property (@(posedge clk_lo) disable iff (!arst_n_i)
    $fell(ack_i) |-> !$past(req_i))
    else
    begin
      $error("ack fell before req was released");
      fail_cnt++;
    end

  mem_v_single_cycle: assert property (@(posedge clk_lo) disable iff (!arst_n_i)
    mem_v_i |=> !mem_v_i)
    else
    begin
      $error("mem_v high for two cycles in a row");
      fail_cnt++;
    end

  // Refused addresses never reach the array.
  mem_v_addr_in_range: assert property (@(posedge clk_lo) disable iff (!arst_n_i)
    mem_v_i |-> (32'(mem_addr_i) < DEPTH))
    else
    begin
      $error("memory access with an out-of-range address");
      fail_cnt++;
    end

endmodule

bind mem_cmd_front mem_subsys_chk #(
  .DEPTH (DEPTH)
) i_mem_subsys_chk (
  .clk_lo     (clk_lo),
  .arst_n_i   (arst_n_i),
  .req_i      (req_i),
  .ack_i      (ack_o),
  .mem_v_i    (mem_v_o),
  .mem_addr_i (mem_addr_o)
);

// ==== tests/mem_subsys_tb.sv ====
`timescale 1ns/1ps

module mem_subsys_tb;

  import mem_cfg_pkg::*;

  localparam int unsigned DEPTH     = MEM_DEPTH_DEF;
  localparam int unsigned ADDR_SPAN = 1 << MEM_ADDR_W;
  localparam int          TIMEOUT   = 40;  // Cycles allowed for any single wait.

  logic        clk_lo;
  logic        arst_n_i;
  logic        req_i;
  logic        we_i;
  addr_t       addr_i;
  data_t       wdata_i;
  mask_t       wmask_i;
  logic        ack_o;
  logic        err_o;
  data_t       rdata_o;
  data_t       model [DEPTH];  // Expected array contents.
  data_t       last_rd;        // Word of the latest in-range read.
  logic [31:0] rng_state;
  int          errors;
  int          tests;
  bit          timed_out;
  data_t       rsp_data;
  logic        rsp_err;

  mem_subsys_top #(
    .DEPTH        (DEPTH),
    .CLOCK_GATING (1'b1)
  ) i_mem_subsys_top (
    .clk_lo   (clk_lo),
    .arst_n_i (arst_n_i),
    .req_i    (req_i),
    .we_i     (we_i),
    .addr_i   (addr_i),
    .wdata_i  (wdata_i),
    .wmask_i  (wmask_i),
    .ack_o    (ack_o),
    .err_o    (err_o),
    .rdata_o  (rdata_o)
  );

  initial
  begin
    clk_lo = 1'b0;
    forever
    begin
      #10 clk_lo = ~clk_lo;
    end
  end

  function automatic logic [31:0] next_rand();
    logic [31:0] x;
    x = rng_state;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    rng_state = x;
    return x;
  endfunction

  // Masked bits take the new data bit by bit.
  function automatic data_t merge_masked(input data_t old_word, input data_t new_word,
                                         input mask_t mask);
    data_t word;
    word = old_word;
    for (int b = 0; b < $bits(data_t); b++)
    begin
      if (mask[b])
      begin
        word[b] = new_word[b];
      end
    end
    return word;
  endfunction

  task automatic mismatch(input string name, input logic [31:0] exp, input logic [31:0] got);
    errors++;
    $display("[ERROR] %s: expected 0x%h, got 0x%h", name, exp, got);
  endtask

  task automatic note_timeout(input string what);
    errors++;
    timed_out = 1'b1;
    $display("Timeout: %s within %0d cycles, remaining commands skipped", what, TIMEOUT);
  endtask

  // One four-phase command, req held for hold extra cycles after ack.
  task automatic transact(input logic we, input addr_t addr, input data_t wdata,
                          input mask_t wmask, input int hold);
    int cnt;
    int exp_lat;
    if (timed_out)
    begin
      return;
    end
    cnt     = 0;
    exp_lat = (32'(addr) < DEPTH) ? 3 : 2;  // Ack is seen one edge after it rises.
    @(posedge clk_lo);
    req_i   <= 1'b1;
    we_i    <= we;
    addr_i  <= addr;
    wdata_i <= wdata;
    wmask_i <= wmask;
    while (ack_o !== 1'b1 && cnt < TIMEOUT)
    begin
      @(posedge clk_lo);
      cnt++;
    end
    if (ack_o !== 1'b1)
    begin
      note_timeout("ack_o did not rise");
      return;
    end
    if (cnt != exp_lat)
    begin
      mismatch("ack_o latency", 32'(exp_lat), 32'(cnt));
    end
    rsp_data = rdata_o;
    rsp_err  = err_o;
    wdata_i <= ~wdata;  // Payload is free after ack. A repeated write would pick it up.
    wmask_i <= '1;
    repeat (hold)
    begin
      @(posedge clk_lo);
      if (ack_o !== 1'b1)
      begin
        mismatch("ack_o", 32'h1, 32'(ack_o));
      end
      if (err_o !== rsp_err)
      begin
        mismatch("err_o", 32'(rsp_err), 32'(err_o));
      end
      if (rdata_o !== rsp_data)
      begin
        mismatch("rdata_o", rsp_data, rdata_o);
      end
    end
    req_i <= 1'b0;
    cnt = 0;
    while (ack_o !== 1'b0 && cnt < TIMEOUT)
    begin
      @(posedge clk_lo);
      cnt++;
    end
    if (ack_o !== 1'b0)
    begin
      note_timeout("ack_o did not fall");
    end
  endtask

  // Runs one command and compares it with the reference model.
  task automatic run_cmd(input logic we, input addr_t addr, input data_t wdata,
                         input mask_t wmask, input int hold);
    logic  exp_err;
    data_t exp_data;
    exp_err  = (32'(addr) >= DEPTH);
    exp_data = last_rd;  // Writes and refused commands keep the last read word.
    if (!exp_err && !we)
    begin
      exp_data = model[addr];
    end
    transact(we, addr, wdata, wmask, hold);
    if (timed_out)
    begin
      return;
    end
    if (rsp_err !== exp_err)
    begin
      mismatch("err_o", 32'(exp_err), 32'(rsp_err));
    end
    if (rsp_data !== exp_data)
    begin
      mismatch("rdata_o", exp_data, rsp_data);
    end
    if (!exp_err && we)
    begin
      model[addr] = merge_masked(model[addr], wdata, wmask);
    end
    last_rd = exp_data;
  endtask

  task automatic finish_test(input string name, input int errs_at_start);
    tests++;
    $display("Test %s finished with %0d error(s)", name, errors - errs_at_start);
  endtask

  task automatic test_reset();
    int e0;
    e0 = errors;
    @(posedge clk_lo);
    if (ack_o !== 1'b0)
    begin
      mismatch("ack_o", 32'h0, 32'(ack_o));
    end
    if (err_o !== 1'b0)
    begin
      mismatch("err_o", 32'h0, 32'(err_o));
    end
    if (rdata_o !== '0)
    begin
      mismatch("rdata_o", 32'h0, rdata_o);
    end
    finish_test("reset_state", e0);
  endtask

  task automatic test_fill();
    int e0;
    e0 = errors;
    for (int a = 0; a < DEPTH; a++)
    begin
      run_cmd(1'b1, addr_t'(a), next_rand(), '1, 0);
    end
    for (int a = 0; a < DEPTH; a++)
    begin
      run_cmd(1'b0, addr_t'(a), '0, '0, 0);
    end
    finish_test("fill_readback", e0);
  endtask

  task automatic test_masked();
    int    e0;
    addr_t a;
    e0 = errors;
    repeat (8)
    begin
      a = addr_t'(next_rand() % DEPTH);
      run_cmd(1'b1, a, next_rand(), next_rand(), 0);
      run_cmd(1'b0, a, '0, '0, 0);
    end
    finish_test("masked_write", e0);
  endtask

  task automatic test_out_of_range();
    int e0;
    e0 = errors;
    run_cmd(1'b1, addr_t'(DEPTH + next_rand() % (ADDR_SPAN - DEPTH)), next_rand(), '1, 0);
    for (int a = 0; a < DEPTH; a++)
    begin
      run_cmd(1'b0, addr_t'(a), '0, '0, 0);
    end
    run_cmd(1'b0, addr_t'(DEPTH + next_rand() % (ADDR_SPAN - DEPTH)), '0, '0, 0);
    finish_test("out_of_range", e0);
  endtask

  // About a quarter of the random addresses fall above DEPTH.
  task automatic test_random();
    int          e0;
    logic [31:0] r;
    e0 = errors;
    repeat (200)
    begin
      r = next_rand();
      run_cmd(r[31], r[5:0], next_rand(), next_rand(), 0);
    end
    finish_test("random_mix", e0);
  endtask

  task automatic test_held();
    int    e0;
    addr_t a;
    e0 = errors;
    a  = addr_t'(next_rand() % DEPTH);
    run_cmd(1'b1, a, next_rand(), next_rand(), 10);
    run_cmd(1'b0, a, '0, '0, 10);
    run_cmd(1'b0, a, '0, '0, 0);
    finish_test("held_request", e0);
  endtask

  initial
  begin
    arst_n_i  = 1'b0;
    req_i     = 1'b0;
    we_i      = 1'b0;
    addr_i    = '0;
    wdata_i   = '0;
    wmask_i   = '0;
    rng_state = 32'h2e55d241;
    errors    = 0;
    tests     = 0;
    timed_out = 1'b0;
    last_rd   = '0;
    repeat (3)
    begin
      @(posedge clk_lo);
    end
    arst_n_i <= 1'b1;
    test_reset();
    test_fill();
    test_masked();
    test_out_of_range();
    test_random();
    test_held();
    if (i_mem_subsys_top.i_mem_cmd_front.i_mem_subsys_chk.fail_cnt != 0)
    begin
      errors += i_mem_subsys_top.i_mem_cmd_front.i_mem_subsys_chk.fail_cnt;
      $display("Bound checker saw %0d failed assertion(s)",
               i_mem_subsys_top.i_mem_cmd_front.i_mem_subsys_chk.fail_cnt);
    end
    $display("Summary: %0d tests run, %0d errors", tests, errors);
    if (errors == 0)
    begin
      $display("TEST PASS");
    end
    else
    begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== src.f ====
logic/mem_cfg_pkg.sv
logic/mem_cmd_pkg.sv
logic/mem_clock_gate.sv
logic/mem_1rw_mask_bit.sv
logic/mem_cmd_front.sv
logic/mem_subsys_top.sv
tests/mem_subsys_chk.sv
tests/mem_subsys_tb.sv

// ==== Makefile ====
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := mem_subsys_tb
FILELIST  := src.f
BUILD_DIR := obj_dir
LOG       := sim.log
PASS_MSG  := TEST PASS

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation, check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG) || { echo "Simulation failed, see $(LOG)"; exit 1; }

clean:
	rm -rf $(BUILD_DIR) $(LOG)
